//--- hw/soc_types_pkg.sv
`default_nettype none

package soc_types_pkg;

    // Bus address and data are both one word wide
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // One PS/2 scan code byte
    typedef logic [7:0] scan_t;

    // Everything the master holds stable while bus_req is high
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  write;
    } bus_cmd_t;

endpackage

`default_nettype wire

//--- hw/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

    // Address map
    localparam soc_types_pkg::addr_t RAM_BASE     = 32'h0000_0000;
    localparam soc_types_pkg::addr_t CONSOLE_ADDR = 32'h8000_0000;
    localparam soc_types_pkg::addr_t KEY_ADDR     = 32'h8000_0010;
    localparam soc_types_pkg::addr_t IRQ_CFG_ADDR = 32'h8000_0014;

    // Read value for holes in the map
    localparam soc_types_pkg::word_t UNMAPPED_DATA = 32'hDEAD_BEEF;

    // Keyboard codes and the vector raised for a key
    localparam soc_types_pkg::scan_t BREAK_PREFIX   = 8'hF0;
    localparam logic [3:0]           KEY_IRQ_VECTOR = 4'd1;

endpackage

`default_nettype wire

//--- hw/ps2_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 ps2_clk,
    input  logic                 ps2_dat,
    output logic                 key_valid,
    output soc_types_pkg::scan_t key_code
);

    logic [1:0]           clk_sync;
    logic [1:0]           dat_sync;
    logic                 clk_prev;
    logic                 fall;
    logic [3:0]           bit_cnt;
    logic [10:0]          idle_cnt;
    logic [10:0]          shreg;
    logic                 frame_done;
    logic                 frame_ok;
    logic                 brk;
    logic                 take_key;
    soc_types_pkg::scan_t frame_byte;

    // Both pins idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign fall = clk_prev & ~clk_sync[1];

    // Bits arrive LSB first, so the start bit ends up in shreg[0]
    always_ff @(posedge CLOCK_50) begin
        if (fall) begin
            shreg <= {dat_sync[1], shreg[10:1]};
        end
    end

    // Bit counter with an idle timeout so a lost edge cannot hang a frame
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                if (idle_cnt == 11'd2047) begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 11'd1;
                end
            end
        end
    end

    // Start low, stop high, odd parity over data plus parity bit
    assign frame_byte = shreg[8:1];
    assign frame_ok   = !shreg[0] && shreg[10] && (^shreg[9:1]);
    assign take_key   = frame_done && frame_ok && !brk
                        && (frame_byte != soc_map_pkg::BREAK_PREFIX);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_valid <= 1'b0;
            brk       <= 1'b0;
        end else begin
            key_valid <= take_key;
            if (frame_done && frame_ok) begin
                // The byte after F0 is a release and only clears the flag
                if (frame_byte == soc_map_pkg::BREAK_PREFIX) begin
                    brk <= 1'b1;
                end else begin
                    brk <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (take_key) begin
            key_code <= frame_byte;
        end
    end

endmodule

`default_nettype wire

//--- hw/key_irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module key_irq_ctrl (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 key_valid,
    input  soc_types_pkg::scan_t key_code,
    input  logic                 key_rd,
    input  logic                 cfg_wr,
    input  logic                 cfg_enable,
    output soc_types_pkg::word_t key_status,
    output logic                 irq_req,
    output logic [3:0]           irq_vector,
    input  logic                 irq_ack
);

    typedef enum logic [1:0] {
        IRQ_IDLE,
        IRQ_REQUEST,
        IRQ_WAIT_RELEASE
    } irq_state_t;

    irq_state_t           state;
    logic                 irq_enable;
    logic                 fresh;
    soc_types_pkg::scan_t latest_key;

    // Config and key registers
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_enable <= 1'b0;
            fresh      <= 1'b0;
            latest_key <= '0;
        end else begin
            if (cfg_wr) begin
                irq_enable <= cfg_enable;
            end
            if (key_valid) begin
                latest_key <= key_code;
                fresh      <= 1'b1;
            end else if (key_rd) begin
                fresh <= 1'b0;
            end
        end
    end

    assign key_status = {15'd0, irq_enable, 7'd0, fresh, latest_key};

    // Keys seen outside IRQ_IDLE are latched above but raise nothing
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= IRQ_IDLE;
        end else begin
            case (state)
                IRQ_IDLE: begin
                    if (key_valid && irq_enable) begin
                        state <= IRQ_REQUEST;
                    end
                end
                IRQ_REQUEST: begin
                    if (irq_ack) begin
                        state <= IRQ_WAIT_RELEASE;
                    end
                end
                IRQ_WAIT_RELEASE: begin
                    if (!irq_ack) begin
                        state <= IRQ_IDLE;
                    end
                end
                default: state <= IRQ_IDLE;
            endcase
        end
    end

    assign irq_req    = (state == IRQ_REQUEST);
    assign irq_vector = irq_req ? soc_map_pkg::KEY_IRQ_VECTOR : 4'd0;

endmodule

`default_nettype wire

//--- hw/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         CLOCK_50,
    input  logic                         en,
    input  logic                         we,
    input  logic [$clog2(RAM_WORDS)-1:0] index,
    input  soc_types_pkg::word_t         wdata,
    output soc_types_pkg::word_t         rdata
);

    soc_types_pkg::word_t mem [RAM_WORDS];

    // Read returns the old word on a write cycle
    always_ff @(posedge CLOCK_50) begin
        if (en) begin
            if (we) begin
                mem[index] <= wdata;
            end
            rdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

//--- hw/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                           CLOCK_50,
    input  logic                           KEY0,
    input  logic                           bus_req,
    input  soc_types_pkg::bus_cmd_t        bus_cmd,
    output logic                           bus_ack,
    output soc_types_pkg::word_t           bus_rdata,
    output logic                           ram_en,
    output logic                           ram_we,
    output logic [$clog2(RAM_WORDS)-1:0]   ram_index,
    output soc_types_pkg::word_t           ram_wdata,
    input  soc_types_pkg::word_t           ram_rdata,
    output logic                           key_rd,
    output logic                           cfg_wr,
    output logic                           cfg_enable,
    input  soc_types_pkg::word_t           key_status,
    output logic                           console_req,
    output soc_types_pkg::scan_t           console_data,
    input  logic                           console_ack
);

    localparam int                   IDX_W     = $clog2(RAM_WORDS);
    localparam soc_types_pkg::addr_t RAM_BYTES = soc_types_pkg::addr_t'(4 * RAM_WORDS);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_CONSOLE,
        ST_RESPOND,
        ST_RELEASE
    } bus_state_t;

    typedef enum logic [2:0] {
        TGT_RAM,
        TGT_KEY,
        TGT_CFG,
        TGT_CONSOLE,
        TGT_NONE
    } target_t;

    bus_state_t              state;
    target_t                 tgt_d;
    target_t                 tgt_q;
    soc_types_pkg::bus_cmd_t cmd_q;
    soc_types_pkg::addr_t    ram_off;
    soc_types_pkg::addr_t    ram_off_q;

    assign ram_off   = bus_cmd.addr - soc_map_pkg::RAM_BASE;
    assign ram_off_q = cmd_q.addr - soc_map_pkg::RAM_BASE;

    // Console only takes writes; a console read falls through to unmapped
    always_comb begin
        if (ram_off < RAM_BYTES) begin
            tgt_d = TGT_RAM;
        end else if (bus_cmd.addr == soc_map_pkg::CONSOLE_ADDR && bus_cmd.write) begin
            tgt_d = TGT_CONSOLE;
        end else if (bus_cmd.addr == soc_map_pkg::KEY_ADDR) begin
            tgt_d = TGT_KEY;
        end else if (bus_cmd.addr == soc_map_pkg::IRQ_CFG_ADDR) begin
            tgt_d = TGT_CFG;
        end else begin
            tgt_d = TGT_NONE;
        end
    end

    // Command is captured once, when the request is first seen
    always_ff @(posedge CLOCK_50) begin
        if (state == ST_IDLE && bus_req) begin
            cmd_q <= bus_cmd;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state       <= ST_IDLE;
            tgt_q       <= TGT_NONE;
            bus_ack     <= 1'b0;
            console_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (bus_req) begin
                        tgt_q <= tgt_d;
                        if (tgt_d == TGT_CONSOLE) begin
                            console_req <= 1'b1;
                            state       <= ST_CONSOLE;
                        end else begin
                            state <= ST_ACCESS;
                        end
                    end
                end
                ST_ACCESS: state <= ST_RESPOND;
                ST_CONSOLE: begin
                    // Held here as long as the console is slow
                    if (console_ack) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    bus_ack     <= 1'b1;
                    console_req <= 1'b0;
                    state       <= ST_RELEASE;
                end
                ST_RELEASE: begin
                    if (!bus_req && !console_ack) begin
                        bus_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Read data mux, registered alongside bus_ack
    always_ff @(posedge CLOCK_50) begin
        if (state == ST_RESPOND) begin
            case (tgt_q)
                TGT_RAM:          bus_rdata <= ram_rdata;
                TGT_KEY, TGT_CFG: bus_rdata <= key_status;
                default:          bus_rdata <= soc_map_pkg::UNMAPPED_DATA;
            endcase
        end
    end

    // One strobe per access to the selected target
    assign ram_en    = (state == ST_ACCESS) && (tgt_q == TGT_RAM);
    assign ram_we    = ram_en && cmd_q.write;
    assign ram_index = ram_off_q[IDX_W+1:2];
    assign ram_wdata = cmd_q.wdata;

    assign cfg_wr     = (state == ST_ACCESS) && (tgt_q == TGT_CFG) && cmd_q.write;
    assign cfg_enable = cmd_q.wdata[0];

    // Fresh flag clears on the same edge the status word is captured
    assign key_rd = (state == ST_RESPOND) && (tgt_q == TGT_KEY) && !cmd_q.write;

    assign console_data = cmd_q.wdata[7:0];

endmodule

`default_nettype wire

//--- hw/board_soc.sv
`timescale 1ns/1ps
`default_nettype none

module board_soc #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  logic                    PS2_CLK,
    input  logic                    PS2_DAT,
    input  logic                    bus_req,
    input  soc_types_pkg::bus_cmd_t bus_cmd,
    output logic                    bus_ack,
    output soc_types_pkg::word_t    bus_rdata,
    output logic                    irq_req,
    output logic [3:0]              irq_vector,
    input  logic                    irq_ack,
    output logic                    console_req,
    output soc_types_pkg::scan_t    console_data,
    input  logic                    console_ack
);

    logic                         key_valid;
    soc_types_pkg::scan_t         key_code;
    logic                         key_rd;
    logic                         cfg_wr;
    logic                         cfg_enable;
    soc_types_pkg::word_t         key_status;
    logic                         ram_en;
    logic                         ram_we;
    logic [$clog2(RAM_WORDS)-1:0] ram_index;
    soc_types_pkg::word_t         ram_wdata;
    soc_types_pkg::word_t         ram_rdata;

    ps2_receiver ps2_receiver_i (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ps2_clk   (PS2_CLK),
        .ps2_dat   (PS2_DAT),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    key_irq_ctrl key_irq_ctrl_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .key_rd     (key_rd),
        .cfg_wr     (cfg_wr),
        .cfg_enable (cfg_enable),
        .key_status (key_status),
        .irq_req    (irq_req),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

    word_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) word_ram_i (
        .CLOCK_50 (CLOCK_50),
        .en       (ram_en),
        .we       (ram_we),
        .index    (ram_index),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata)
    );

    bus_decoder #(
        .RAM_WORDS (RAM_WORDS)
    ) bus_decoder_i (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .bus_req      (bus_req),
        .bus_cmd      (bus_cmd),
        .bus_ack      (bus_ack),
        .bus_rdata    (bus_rdata),
        .ram_en       (ram_en),
        .ram_we       (ram_we),
        .ram_index    (ram_index),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata),
        .key_rd       (key_rd),
        .cfg_wr       (cfg_wr),
        .cfg_enable   (cfg_enable),
        .key_status   (key_status),
        .console_req  (console_req),
        .console_data (console_data),
        .console_ack  (console_ack)
    );

endmodule

`default_nettype wire

//--- dv/board_soc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module board_soc_checker (
    input logic                    CLOCK_50,
    input logic                    KEY0,
    input logic                    bus_req,
    input soc_types_pkg::bus_cmd_t bus_cmd,
    input logic                    bus_ack,
    input logic                    irq_req,
    input logic [3:0]              irq_vector,
    input logic                    irq_ack,
    input logic                    console_req,
    input soc_types_pkg::scan_t    console_data,
    input logic                    console_ack,
    input soc_types_pkg::word_t    key_status
);

    int fail_count;

    initial fail_count = 0;

    task automatic record_failure(input string what);
        $error("%s", what);
        fail_count++;
    endtask

    a_reset_idle: assert property (@(posedge CLOCK_50)
        !KEY0 |-> !bus_ack && !irq_req && !console_req)
        else record_failure("Handshake output active during reset");

    // Non-console ack lands 3 samples after the first sample of bus_req high
    a_ack_latency: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(bus_ack) && !$past(console_req) |-> $past(bus_req, 3) && !$past(bus_req, 4))
        else record_failure("bus_ack latency is not 2 cycles");

    a_ack_hold: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_ack && bus_req |=> bus_ack)
        else record_failure("bus_ack fell while bus_req was high");

    a_console_hold: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        console_req && !console_ack |=> console_req)
        else record_failure("console_req dropped before console_ack");

    a_console_no_ack: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        console_req |-> !bus_ack)
        else record_failure("bus_ack high while console_req high");

    a_console_data: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        console_req |-> console_data == bus_cmd.wdata[7:0])
        else record_failure("console_data differs from the write data low byte");

    a_irq_vector: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_req |-> irq_vector == soc_map_pkg::KEY_IRQ_VECTOR)
        else record_failure("Wrong irq_vector");

    // Enable bit lives in key_status bit 16
    a_irq_rise: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(irq_req) |-> !irq_ack && key_status[16])
        else record_failure("irq_req rose while irq_ack high or interrupts disabled");

    a_irq_drop: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_req && irq_ack |=> !irq_req)
        else record_failure("irq_req did not drop one cycle after irq_ack");

endmodule

bind board_soc board_soc_checker board_soc_checker_i (
    .CLOCK_50     (CLOCK_50),
    .KEY0         (KEY0),
    .bus_req      (bus_req),
    .bus_cmd      (bus_cmd),
    .bus_ack      (bus_ack),
    .irq_req      (irq_req),
    .irq_vector   (irq_vector),
    .irq_ack      (irq_ack),
    .console_req  (console_req),
    .console_data (console_data),
    .console_ack  (console_ack),
    .key_status   (key_status)
);

`default_nettype wire

//--- dv/board_soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_soc_tb;

    localparam int RAM_WORDS   = 1024;
    localparam int WAIT_LIMIT  = 2000;
    localparam int RUN_LIMIT   = 100000;
    localparam int PS2_QUARTER = 8;

    logic                    CLOCK_50;
    logic                    KEY0;
    logic                    PS2_CLK;
    logic                    PS2_DAT;
    logic                    bus_req;
    soc_types_pkg::bus_cmd_t bus_cmd;
    logic                    bus_ack;
    soc_types_pkg::word_t    bus_rdata;
    logic                    irq_req;
    logic [3:0]              irq_vector;
    logic                    irq_ack;
    logic                    console_req;
    soc_types_pkg::scan_t    console_data;
    logic                    console_ack;
    integer                  seed;
    soc_types_pkg::word_t    rd_word;

    board_soc #(.RAM_WORDS (RAM_WORDS)) board_soc_i (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever begin
            #50 CLOCK_50 = ~CLOCK_50;
        end
    end

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input soc_types_pkg::word_t got,
                              input soc_types_pkg::word_t exp);
        assert (got == exp)
        else stop_on_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
                                       name, got, exp));
    endtask

    // Key status word has the code in 7:0, the fresh flag in bit 8 and enable in bit 16
    function automatic soc_types_pkg::word_t key_word(input logic enable, input logic fresh,
                                                      input soc_types_pkg::scan_t code);
        soc_types_pkg::word_t w;
        w        = 32'd0;
        w[7:0]   = code;
        w[8]     = fresh;
        w[16]    = enable;
        return w;
    endfunction

    task automatic bus_access(input soc_types_pkg::addr_t addr, input logic write,
                              input soc_types_pkg::word_t wdata,
                              output soc_types_pkg::word_t rdata);
        int n;
        bus_cmd <= '{addr: addr, wdata: wdata, write: write};
        @(posedge CLOCK_50);
        bus_req <= 1'b1;
        n = 0;
        do begin
            @(posedge CLOCK_50);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_failure("Timeout: bus_ack never rose");
            end
        end while (!bus_ack);
        rdata = bus_rdata;
        bus_req <= 1'b0;
        n = 0;
        do begin
            @(posedge CLOCK_50);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_failure("Timeout: bus_ack never fell");
            end
        end while (bus_ack);
    endtask

    // Console side of the handshake, with a random ack delay
    task automatic serve_console(input soc_types_pkg::scan_t expected);
        int n;
        int delay;
        n = 0;
        while (!console_req) begin
            @(posedge CLOCK_50);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_failure("Timeout: console_req never rose");
            end
        end
        check_word("console_data", {24'd0, console_data}, {24'd0, expected});
        delay = $unsigned($random(seed)) % 10;
        repeat (delay) @(posedge CLOCK_50);
        console_ack <= 1'b1;
        n = 0;
        while (console_req) begin
            @(posedge CLOCK_50);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_failure("Timeout: console_req never fell");
            end
        end
        console_ack <= 1'b0;
    endtask

    task automatic serve_irq;
        int n;
        n = 0;
        while (!irq_req) begin
            @(posedge CLOCK_50);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_failure("Timeout: irq_req never rose");
            end
        end
        irq_ack <= 1'b1;
        n = 0;
        while (irq_req) begin
            @(posedge CLOCK_50);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_failure("Timeout: irq_req never fell");
            end
        end
        irq_ack <= 1'b0;
    endtask

    // Data changes in the middle of the high clock phase and is sampled on the fall
    task automatic send_ps2_frame(input soc_types_pkg::scan_t code, input logic good_parity);
        logic [10:0] frame;
        logic        parity;
        int          i;
        parity = good_parity ? ~^code : ^code;
        frame  = {1'b1, parity, code, 1'b0};
        for (i = 0; i < 11; i++) begin
            PS2_DAT <= frame[i];
            repeat (PS2_QUARTER) @(posedge CLOCK_50);
            PS2_CLK <= 1'b0;
            repeat (2 * PS2_QUARTER) @(posedge CLOCK_50);
            PS2_CLK <= 1'b1;
            repeat (PS2_QUARTER) @(posedge CLOCK_50);
        end
        PS2_DAT <= 1'b1;
        repeat (4 * PS2_QUARTER) @(posedge CLOCK_50);
    endtask

    always @(posedge CLOCK_50) begin
        if (board_soc_i.board_soc_checker_i.fail_count != 0) begin
            stop_on_failure("A bound assertion failed");
        end
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge CLOCK_50);
        stop_on_failure("Watchdog expired before the test finished");
    end

    initial begin
        int                   i;
        soc_types_pkg::addr_t idx_list [16];
        soc_types_pkg::word_t ram_expect [soc_types_pkg::addr_t];
        soc_types_pkg::addr_t addr;
        soc_types_pkg::word_t data;
        seed        = 32'h12c7_6e53;
        KEY0        = 1'b0;
        PS2_CLK     = 1'b1;
        PS2_DAT     = 1'b1;
        bus_req     = 1'b0;
        bus_cmd     = '0;
        irq_ack     = 1'b0;
        console_ack = 1'b0;
        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(posedge CLOCK_50);

        // RAM words at random indices, all written before any is read back
        for (i = 0; i < 16; i++) begin
            idx_list[i] = $unsigned($random(seed)) % RAM_WORDS;
            data        = $random(seed);
            addr        = soc_map_pkg::RAM_BASE + (idx_list[i] << 2);
            ram_expect[idx_list[i]] = data;
            bus_access(addr, 1'b1, data, rd_word);
        end
        for (i = 0; i < 16; i++) begin
            addr = soc_map_pkg::RAM_BASE + (idx_list[i] << 2);
            bus_access(addr, 1'b0, '0, rd_word);
            check_word("bus_rdata", rd_word, ram_expect[idx_list[i]]);
        end

        // Holes in the map, including the word just past the RAM
        bus_access(32'h4000_0000, 1'b0, '0, rd_word);
        check_word("bus_rdata", rd_word, soc_map_pkg::UNMAPPED_DATA);
        bus_access(soc_map_pkg::RAM_BASE, 1'b1, 32'h1357_9bdf, rd_word);
        bus_access(soc_types_pkg::addr_t'(4 * RAM_WORDS), 1'b1, 32'hffff_0000, rd_word);
        bus_access(32'h4000_0000, 1'b1, 32'h0f0f_0f0f, rd_word);
        bus_access(soc_types_pkg::addr_t'(4 * RAM_WORDS), 1'b0, '0, rd_word);
        check_word("bus_rdata", rd_word, soc_map_pkg::UNMAPPED_DATA);
        bus_access(soc_map_pkg::RAM_BASE, 1'b0, '0, rd_word);
        check_word("bus_rdata", rd_word, 32'h1357_9bdf);

        for (i = 0; i < 4; i++) begin
            data = $random(seed);
            fork
                bus_access(soc_map_pkg::CONSOLE_ADDR, 1'b1, data, rd_word);
                serve_console(data[7:0]);
            join
        end

        // Enabled key raises an interrupt and the first read clears the fresh flag
        bus_access(soc_map_pkg::IRQ_CFG_ADDR, 1'b1, 32'd1, rd_word);
        fork
            send_ps2_frame(8'h1c, 1'b1);
            serve_irq();
        join
        bus_access(soc_map_pkg::KEY_ADDR, 1'b0, '0, rd_word);
        check_word("key_status", rd_word, key_word(1'b1, 1'b1, 8'h1c));
        bus_access(soc_map_pkg::KEY_ADDR, 1'b0, '0, rd_word);
        check_word("key_status", rd_word, key_word(1'b1, 1'b0, 8'h1c));

        bus_access(soc_map_pkg::IRQ_CFG_ADDR, 1'b1, 32'd0, rd_word);
        send_ps2_frame(8'h32, 1'b1);
        check_word("irq_req", {31'd0, irq_req}, 32'd0);
        bus_access(soc_map_pkg::KEY_ADDR, 1'b0, '0, rd_word);
        check_word("key_status", rd_word, key_word(1'b0, 1'b1, 8'h32));
        bus_access(soc_map_pkg::KEY_ADDR, 1'b0, '0, rd_word);
        check_word("key_status", rd_word, key_word(1'b0, 1'b0, 8'h32));

        // Bad parity is dropped
        send_ps2_frame(8'h45, 1'b0);
        bus_access(soc_map_pkg::KEY_ADDR, 1'b0, '0, rd_word);
        check_word("key_status", rd_word, key_word(1'b0, 1'b0, 8'h32));

        // Break sequence with interrupts enabled
        bus_access(soc_map_pkg::IRQ_CFG_ADDR, 1'b1, 32'd1, rd_word);
        send_ps2_frame(soc_map_pkg::BREAK_PREFIX, 1'b1);
        send_ps2_frame(8'h1c, 1'b1);
        check_word("irq_req", {31'd0, irq_req}, 32'd0);
        bus_access(soc_map_pkg::KEY_ADDR, 1'b0, '0, rd_word);
        check_word("key_status", rd_word, key_word(1'b1, 1'b0, 8'h32));

        repeat (4) @(posedge CLOCK_50);
        if (board_soc_i.board_soc_checker_i.fail_count != 0) begin
            stop_on_failure("Bound assertions reported failures");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- board_soc.f
hw/soc_types_pkg.sv
hw/soc_map_pkg.sv
hw/ps2_receiver.sv
hw/key_irq_ctrl.sv
hw/word_ram.sv
hw/bus_decoder.sv
hw/board_soc.sv
dv/board_soc_checker.sv
dv/board_soc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the board_soc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
    -f board_soc.f --top-module board_soc_tb -o board_soc_sim
./obj_dir/board_soc_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
